// File: flist.f
+incdir+common
common/isa_types.sv
common/pipeline_types.sv
common/dispatch_regfile.sv
regfile/regfile.sv
logic/stage_reg.sv
logic/decoder.sv
logic/dispatch.sv
logic/execute.sv
logic/mem_stage.sv
logic/backend.sv
testbench/tb_backend.sv

// File: Makefile
TOP = tb_backend

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: testbench/tb_backend.sv
`timescale 1ns/10ps

module tb_backend;

    localparam int          ACK_LIMIT   = 40;
    localparam int          DROP_LIMIT  = 8;
    localparam int          DRAIN_LIMIT = 60;
    localparam logic [31:0] RESET_PC    = 32'h1c00_0000;

    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;
    localparam logic [9:0]  OPC_LD_W    = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W    = 10'h0a6;
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        wen;
        logic [4:0]  wnum;
        logic [31:0] wdata;
    } commit_t;

    typedef enum logic [1:0] {
        RSP_IDLE,
        RSP_DELAY,
        RSP_DROP
    } rsp_phase_t;

    logic        clk;
    logic        rst_n_i      = 1'b0;
    logic        fetch_req_i  = 1'b0;
    logic        fetch_ack_o;
    logic [31:0] pc_i         = '0;
    logic [31:0] inst_i       = '0;
    logic        dmem_req_o;
    logic        dmem_ack_i   = 1'b0;
    logic        dmem_we_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic [31:0] dmem_rdata_i = '0;
    logic        wb_valid_o;
    logic [31:0] wb_pc_o;
    logic        wb_rf_wen_o;
    logic [4:0]  wb_rf_wnum_o;
    logic [31:0] wb_rf_wdata_o;
    logic [31:0] wb_inst_o;

    // reference model state
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [logic [31:0]];
    commit_t     exp_q [$];
    logic [31:0] pc_next      = RESET_PC;
    int          issue_count  = 0;
    int          commit_count = 0;
    string       test_name    = "reset";

    // memory responder state
    logic [31:0] dmem [logic [31:0]];
    rsp_phase_t  rsp_phase    = RSP_IDLE;
    logic [1:0]  wait_left    = 2'd0;
    int          drop_wait    = 0;
    logic [15:0] lfsr_q       = 16'd29676;

    backend u_backend (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
            stop_run();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // unwritten words read back as a pattern of their address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c5a_a5c3;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
    endfunction

    task automatic answer_request();
        if (dmem_we_o) begin
            dmem[dmem_addr_o] = dmem_wdata_o;
        end
        dmem_rdata_i <= dmem.exists(dmem_addr_o) ? dmem[dmem_addr_o]
                                                  : fill_word(dmem_addr_o);
        dmem_ack_i   <= 1'b1;
        drop_wait = 0;
        rsp_phase = RSP_DROP;
    endtask

    // data memory answering 0 to 3 cycles after a request
    always @(posedge clk) begin
        if (!rst_n_i) begin
            dmem_ack_i <= 1'b0;
            rsp_phase = RSP_IDLE;
        end else begin
            case (rsp_phase)
                RSP_IDLE: begin
                    if (dmem_req_o) begin
                        lfsr_q = lfsr_step(lfsr_q);
                        wait_left[0] = lfsr_q[0];
                        lfsr_q = lfsr_step(lfsr_q);
                        wait_left[1] = lfsr_q[0];
                        if (wait_left == 2'd0) begin
                            answer_request();
                        end else begin
                            rsp_phase = RSP_DELAY;
                        end
                    end
                end
                RSP_DELAY: begin
                    wait_left = wait_left - 2'd1;
                    if (wait_left == 2'd0) begin
                        answer_request();
                    end
                end
                default: begin
                    if (!dmem_req_o) begin
                        dmem_ack_i <= 1'b0;
                        rsp_phase = RSP_IDLE;
                    end else if (drop_wait > DROP_LIMIT) begin
                        $display("dmem_req_o stayed high after the ack in %s", test_name);
                        stop_run();
                    end else begin
                        drop_wait++;
                    end
                end
            endcase
        end
    end

    // in-order commit check
    always @(posedge clk) begin : commit_monitor
        commit_t c;
        if (rst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("commit at pc 0x%08h with nothing outstanding", wb_pc_o);
                stop_run();
            end else begin
                c = exp_q.pop_front();
                commit_count++;
                check("pc", c.pc, wb_pc_o);
                check("inst", c.inst, wb_inst_o);
                check("wen", 32'(c.wen), 32'(wb_rf_wen_o));
                if (c.wen) begin
                    check("wnum", 32'(c.wnum), 32'(wb_rf_wnum_o));
                    check("wdata", c.wdata, wb_rf_wdata_o);
                end
            end
        end
    end

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > ACK_LIMIT) begin
                $display("fetch_ack_o did not reach %0b within %0d cycles in %s",
                         level, ACK_LIMIT, test_name);
                stop_run();
            end
        end while (fetch_ack_o !== level);
    endtask

    // one four-phase fetch transfer
    task automatic fetch_one(input logic [31:0] inst);
        fetch_req_i <= 1'b1;
        pc_i        <= pc_next;
        inst_i      <= inst;
        wait_ack(1'b1);
        fetch_req_i <= 1'b0;
        wait_ack(1'b0);
        pc_next = pc_next + 32'd4;
    endtask

    task automatic issue(input logic [31:0] inst, input logic wen, input logic [4:0] rd,
                         input logic [31:0] data);
        commit_t c;
        c.pc    = pc_next;
        c.inst  = inst;
        c.wen   = wen && (rd != 5'd0);
        c.wnum  = rd;
        c.wdata = data;
        if (c.wen) begin
            ref_regs[rd] = data;
        end
        exp_q.push_back(c);
        issue_count++;
        fetch_one(inst);
    endtask

    task automatic alu_3r(input logic [16:0] op, input logic [4:0] rd, rj, rk);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = ref_regs[rj];
        b = ref_regs[rk];
        case (op)
            OPC_ADD_W: r = a + b;
            OPC_SUB_W: r = a - b;
            OPC_AND:   r = a & b;
            OPC_OR:    r = a | b;
            OPC_XOR:   r = a ^ b;
            OPC_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:   r = 32'd0;
        endcase
        issue({op, rk, rj, rd}, 1'b1, rd, r);
    endtask

    task automatic addi_w(input logic [4:0] rd, rj, input logic [11:0] si12);
        issue({OPC_ADDI_W, si12, rj, rd}, 1'b1, rd, ref_regs[rj] + {{20{si12[11]}}, si12});
    endtask

    task automatic lu12i_w(input logic [4:0] rd, input logic [19:0] si20);
        issue({OPC_LU12I_W, si20, rd}, 1'b1, rd, {si20, 12'h000});
    endtask

    task automatic ld_w(input logic [4:0] rd, rj, input logic [11:0] si12);
        logic [31:0] addr;
        addr = ref_regs[rj] + {{20{si12[11]}}, si12};
        issue({OPC_LD_W, si12, rj, rd}, 1'b1, rd, mem_word(addr));
    endtask

    task automatic st_w(input logic [4:0] rd, rj, input logic [11:0] si12);
        logic [31:0] addr;
        addr = ref_regs[rj] + {{20{si12[11]}}, si12};
        ref_mem[addr] = ref_regs[rd];
        issue({OPC_ST_W, si12, rj, rd}, 1'b0, rd, 32'd0);
    endtask

    task automatic raw_inst(input logic [31:0] inst);
        issue(inst, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > DRAIN_LIMIT) begin
                $display("%0d commits still missing in %s", exp_q.size(), test_name);
                stop_run();
            end
        end
    endtask

    task automatic check_reset_state();
        check("fetch_ack_o", 32'd0, 32'(fetch_ack_o));
        check("dmem_req_o", 32'd0, 32'(dmem_req_o));
        check("wb_valid_o", 32'd0, 32'(wb_valid_o));
        check("wb_rf_wen_o", 32'd0, 32'(wb_rf_wen_o));
    endtask

    task automatic alu_immediate_ops();
        test_name = "alu_immediate";
        addi_w(5'd1, 5'd0, 12'd5);
        addi_w(5'd2, 5'd0, 12'hffd);
        lu12i_w(5'd3, 20'h12345);
        lu12i_w(5'd4, 20'h80001);
        alu_3r(OPC_ADD_W, 5'd5, 5'd1, 5'd2);
        alu_3r(OPC_SUB_W, 5'd6, 5'd1, 5'd2);
        alu_3r(OPC_AND, 5'd7, 5'd3, 5'd4);
        alu_3r(OPC_OR, 5'd8, 5'd3, 5'd4);
        alu_3r(OPC_XOR, 5'd9, 5'd3, 5'd4);
        // signed compares of negative against positive
        alu_3r(OPC_SLT, 5'd10, 5'd2, 5'd1);
        alu_3r(OPC_SLT, 5'd11, 5'd1, 5'd2);
        alu_3r(OPC_SLT, 5'd12, 5'd4, 5'd3);
        alu_3r(OPC_SLT, 5'd30, 5'd2, 5'd2);
        drain();
    endtask

    task automatic dependent_chain();
        test_name = "dependent_chain";
        addi_w(5'd13, 5'd0, 12'd100);
        addi_w(5'd13, 5'd13, 12'd1);
        alu_3r(OPC_ADD_W, 5'd14, 5'd13, 5'd13);
        alu_3r(OPC_SUB_W, 5'd15, 5'd14, 5'd13);
        alu_3r(OPC_XOR, 5'd13, 5'd15, 5'd14);
        alu_3r(OPC_SLT, 5'd29, 5'd13, 5'd15);
        addi_w(5'd29, 5'd29, 12'h800);
        drain();
    endtask

    task automatic store_then_load();
        int i;
        test_name = "store_then_load";
        lu12i_w(5'd16, 20'h00010);
        addi_w(5'd17, 5'd0, 12'h5a5);
        st_w(5'd17, 5'd16, 12'd8);
        ld_w(5'd18, 5'd16, 12'd8);
        st_w(5'd5, 5'd16, 12'hffc);
        ld_w(5'd19, 5'd16, 12'hffc);
        for (i = 0; i < 6; i++) begin
            addi_w(5'd20, 5'd0, 12'(i * 37 + 1));
            st_w(5'd20, 5'd16, 12'(i * 4 + 16));
            ld_w(5'd21, 5'd16, 12'(i * 4 + 16));
        end
        ld_w(5'd22, 5'd16, 12'h100);
        drain();
    endtask

    task automatic load_then_use();
        test_name = "load_then_use";
        ld_w(5'd23, 5'd16, 12'd8);
        alu_3r(OPC_ADD_W, 5'd24, 5'd23, 5'd23);
        ld_w(5'd25, 5'd16, 12'hffc);
        addi_w(5'd25, 5'd25, 12'h7ff);
        st_w(5'd25, 5'd16, 12'd40);
        ld_w(5'd28, 5'd16, 12'd40);
        alu_3r(OPC_SUB_W, 5'd28, 5'd28, 5'd23);
        drain();
    endtask

    task automatic r0_writes();
        test_name = "r0_writes";
        addi_w(5'd0, 5'd0, 12'd77);
        alu_3r(OPC_OR, 5'd0, 5'd1, 5'd2);
        ld_w(5'd0, 5'd16, 12'd8);
        alu_3r(OPC_ADD_W, 5'd26, 5'd0, 5'd1);
        alu_3r(OPC_ADD_W, 5'd27, 5'd0, 5'd0);
        drain();
    endtask

    task automatic unknown_encoding();
        int i;
        test_name = "unknown_encoding";
        raw_inst(32'hffff_ffff);
        raw_inst(32'h0000_0000);
        raw_inst(32'h0010_8c41);
        // read back every register through r31
        for (i = 1; i < 31; i++) begin
            alu_3r(OPC_OR, 5'd31, 5'(i), 5'd0);
        end
        drain();
    endtask

    initial begin
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        check_reset_state();
        alu_immediate_ops();
        dependent_chain();
        store_then_load();
        load_then_use();
        r0_writes();
        unknown_encoding();
        // no stray commits allowed while idle
        test_name = "idle";
        repeat (10) @(posedge clk);
        if (commit_count == issue_count && exp_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("%0d commits seen for %0d instructions", commit_count, issue_count);
            stop_run();
        end
    end

endmodule

// File: logic/backend.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module backend (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // front end
    input  logic                   fetch_req_i,
    output logic                   fetch_ack_o,
    input  logic [`DATA_W-1:0]     pc_i,
    input  logic [`DATA_W-1:0]     inst_i,
    // data memory
    output logic                   dmem_req_o,
    input  logic                   dmem_ack_i,
    output logic                   dmem_we_o,
    output logic [`DATA_W-1:0]     dmem_addr_o,
    output logic [`DATA_W-1:0]     dmem_wdata_o,
    input  logic [`DATA_W-1:0]     dmem_rdata_i,
    // commit record
    output logic                   wb_valid_o,
    output logic [`DATA_W-1:0]     wb_pc_o,
    output logic                   wb_rf_wen_o,
    output logic [`REG_ADDR_W-1:0] wb_rf_wnum_o,
    output logic [`DATA_W-1:0]     wb_rf_wdata_o,
    output logic [`DATA_W-1:0]     wb_inst_o
);
    import pipeline_types::*;

    dispatch_regfile dispatch_regfile_io ();

    pause_t        pause;
    logic          id_taken;
    id_dispatch_t  id_o;
    id_dispatch_t  dispatch_i;
    dispatch_ex_t  dispatch_o;
    dispatch_ex_t  ex_i;
    ex_mem_t       ex_o;
    ex_mem_t       mem_i;
    mem_wb_t       mem_o;
    mem_wb_t       wb;
    push_forward_t ex_push_forward;
    push_forward_t mem_push_forward;
    logic          ex_is_load;

    decoder u_decoder (
        .clk,
        .rst_n_i,
        .fetch_req_i,
        .fetch_ack_o,
        .pc_i,
        .inst_i,
        .taken_i (id_taken),
        .id_o    (id_o)
    );

    stage_reg #(.payload_t(id_dispatch_t), .STAGE(`STAGE_ID)) u_id_dispatch (
        .clk,
        .rst_n_i,
        .pause_i (pause),
        .d_i     (id_o),
        .q_o     (dispatch_i),
        .taken_o (id_taken)
    );

    dispatch u_dispatch (
        .id_dispatch_i      (dispatch_i),
        .rf                 (dispatch_regfile_io.master),
        .ex_push_forward_i  (ex_push_forward),
        .ex_is_load_i       (ex_is_load),
        .mem_push_forward_i (mem_push_forward),
        .pause_dispatch_o   (pause.pause_dispatch),
        .dispatch_ex_o      (dispatch_o)
    );

    regfile u_regfile (
        .clk,
        .rst_n_i,
        .wb_i (wb),
        .rf   (dispatch_regfile_io.slave)
    );

    stage_reg #(.payload_t(dispatch_ex_t), .STAGE(`STAGE_DISPATCH)) u_dispatch_ex (
        .clk,
        .rst_n_i,
        .pause_i (pause),
        .d_i     (dispatch_o),
        .q_o     (ex_i),
        .taken_o ()
    );

    execute u_execute (
        .dispatch_ex_i     (ex_i),
        .ex_mem_o          (ex_o),
        .ex_push_forward_o (ex_push_forward),
        .ex_is_load_o      (ex_is_load)
    );

    stage_reg #(.payload_t(ex_mem_t), .STAGE(`STAGE_EX)) u_ex_mem (
        .clk,
        .rst_n_i,
        .pause_i (pause),
        .d_i     (ex_o),
        .q_o     (mem_i),
        .taken_o ()
    );

    mem_stage u_mem_stage (
        .clk,
        .rst_n_i,
        .ex_mem_i           (mem_i),
        .dmem_req_o,
        .dmem_ack_i,
        .dmem_we_o,
        .dmem_addr_o,
        .dmem_wdata_o,
        .dmem_rdata_i,
        .pause_mem_o        (pause.pause_mem),
        .mem_wb_o           (mem_o),
        .mem_push_forward_o (mem_push_forward)
    );

    stage_reg #(.payload_t(mem_wb_t), .STAGE(`STAGE_MEM)) u_mem_wb (
        .clk,
        .rst_n_i,
        .pause_i (pause),
        .d_i     (mem_o),
        .q_o     (wb),
        .taken_o ()
    );

    assign wb_valid_o    = wb.valid;
    assign wb_pc_o       = wb.pc;
    assign wb_rf_wen_o   = wb.valid && wb.we;
    assign wb_rf_wnum_o  = wb.rd;
    assign wb_rf_wdata_o = wb.wdata;
    assign wb_inst_o     = wb.inst;

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module mem_stage (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  pipeline_types::ex_mem_t       ex_mem_i,
    output logic                          dmem_req_o,
    input  logic                          dmem_ack_i,
    output logic                          dmem_we_o,
    output logic [`DATA_W-1:0]            dmem_addr_o,
    output logic [`DATA_W-1:0]            dmem_wdata_o,
    input  logic [`DATA_W-1:0]            dmem_rdata_i,
    output logic                          pause_mem_o,
    output pipeline_types::mem_wb_t       mem_wb_o,
    output pipeline_types::push_forward_t mem_push_forward_o
);
    import isa_types::*;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_REQ,
        MEM_WAIT_DROP,
        MEM_DONE
    } mem_state_t;

    mem_state_t         state_q;
    mem_state_t         state_d;
    logic               is_load;
    logic               is_mem_op;
    logic [`DATA_W-1:0] rdata_q;

    assign is_load   = ex_mem_i.aluop == ALU_LOAD;
    assign is_mem_op = ex_mem_i.valid && (is_load || ex_mem_i.aluop == ALU_STORE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            MEM_IDLE: begin
                if (is_mem_op) begin
                    state_d = MEM_REQ;
                end
            end
            MEM_REQ: begin
                if (dmem_ack_i) begin
                    state_d = MEM_WAIT_DROP;
                end
            end
            MEM_WAIT_DROP: begin
                if (!dmem_ack_i) begin
                    state_d = MEM_DONE;
                end
            end
            default: state_d = MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= MEM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MEM_REQ && dmem_ack_i) begin
            rdata_q <= dmem_rdata_i;
        end
    end

    assign dmem_req_o   = state_q == MEM_REQ;
    assign dmem_we_o    = ex_mem_i.aluop == ALU_STORE;
    assign dmem_addr_o  = ex_mem_i.result;
    assign dmem_wdata_o = ex_mem_i.store_data;

    // held until the ack has fallen again
    assign pause_mem_o = is_mem_op && state_q != MEM_DONE;

    always_comb begin
        mem_wb_o.valid = ex_mem_i.valid && !pause_mem_o;
        mem_wb_o.pc    = ex_mem_i.pc;
        mem_wb_o.inst  = ex_mem_i.inst;
        mem_wb_o.we    = ex_mem_i.we;
        mem_wb_o.rd    = ex_mem_i.rd;
        mem_wb_o.wdata = is_load ? rdata_q : ex_mem_i.result;
    end

    assign mem_push_forward_o.we   = mem_wb_o.valid && mem_wb_o.we;
    assign mem_push_forward_o.addr = mem_wb_o.rd;
    assign mem_push_forward_o.data = mem_wb_o.wdata;

    // relies on the ex/mem register holding during the pause
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_req_o |=> !dmem_req_o || $stable(dmem_addr_o));

endmodule

// File: logic/execute.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module execute (
    input  pipeline_types::dispatch_ex_t  dispatch_ex_i,
    output pipeline_types::ex_mem_t       ex_mem_o,
    output pipeline_types::push_forward_t ex_push_forward_o,
    output logic                          ex_is_load_o
);
    import isa_types::*;

    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] result;
    logic               is_load;

    assign a       = dispatch_ex_i.opa;
    assign b       = dispatch_ex_i.opb;
    assign is_load = dispatch_ex_i.aluop == ALU_LOAD;

    always_comb begin
        case (dispatch_ex_i.aluop)
            ALU_ADD, ALU_LOAD, ALU_STORE: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_LUI: result = b << 12;
            default: result = '0;
        endcase
    end

    always_comb begin
        ex_mem_o.valid      = dispatch_ex_i.valid;
        ex_mem_o.pc         = dispatch_ex_i.pc;
        ex_mem_o.inst       = dispatch_ex_i.inst;
        ex_mem_o.aluop      = dispatch_ex_i.aluop;
        ex_mem_o.result     = result;
        ex_mem_o.store_data = dispatch_ex_i.store_data;
        ex_mem_o.rd         = dispatch_ex_i.rd;
        ex_mem_o.we         = dispatch_ex_i.we;
    end

    // address stays visible so dispatch can spot a load-use hazard
    assign ex_push_forward_o.we   = dispatch_ex_i.valid && dispatch_ex_i.we && !is_load;
    assign ex_push_forward_o.addr = dispatch_ex_i.rd;
    assign ex_push_forward_o.data = result;
    assign ex_is_load_o           = dispatch_ex_i.valid && dispatch_ex_i.we && is_load;

endmodule

// File: logic/dispatch.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module dispatch (
    input  pipeline_types::id_dispatch_t  id_dispatch_i,
    dispatch_regfile.master               rf,
    input  pipeline_types::push_forward_t ex_push_forward_i,
    input  logic                          ex_is_load_i,
    input  pipeline_types::push_forward_t mem_push_forward_i,
    output logic                          pause_dispatch_o,
    output pipeline_types::dispatch_ex_t  dispatch_ex_o
);
    import pipeline_types::*;

    logic [`DATA_W-1:0] reg1_val;
    logic [`DATA_W-1:0] reg2_val;

    // execute has priority over memory and memory over the file
    function automatic logic [`DATA_W-1:0] pick(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`DATA_W-1:0]     file_data,
        input push_forward_t          ex_fwd,
        input push_forward_t          mem_fwd
    );
        logic [`DATA_W-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_fwd.we && ex_fwd.addr == addr) begin
            value = ex_fwd.data;
        end else if (mem_fwd.we && mem_fwd.addr == addr) begin
            value = mem_fwd.data;
        end else begin
            value = file_data;
        end
        return value;
    endfunction

    assign rf.reg1_addr = id_dispatch_i.reg1_addr;
    assign rf.reg2_addr = id_dispatch_i.reg2_addr;

    assign reg1_val = pick(id_dispatch_i.reg1_addr, rf.reg1_data,
                           ex_push_forward_i, mem_push_forward_i);
    assign reg2_val = pick(id_dispatch_i.reg2_addr, rf.reg2_data,
                           ex_push_forward_i, mem_push_forward_i);

    // a load in execute has no data to forward yet
    assign pause_dispatch_o = id_dispatch_i.valid && ex_is_load_i &&
                              (id_dispatch_i.reg1_addr == ex_push_forward_i.addr ||
                               id_dispatch_i.reg2_addr == ex_push_forward_i.addr);

    always_comb begin
        dispatch_ex_o.valid      = id_dispatch_i.valid && !pause_dispatch_o;
        dispatch_ex_o.pc         = id_dispatch_i.pc;
        dispatch_ex_o.inst       = id_dispatch_i.inst;
        dispatch_ex_o.aluop      = id_dispatch_i.aluop;
        dispatch_ex_o.opa        = reg1_val;
        dispatch_ex_o.opb        = id_dispatch_i.use_imm ? id_dispatch_i.imm : reg2_val;
        dispatch_ex_o.store_data = reg2_val;
        dispatch_ex_o.rd         = id_dispatch_i.rd;
        dispatch_ex_o.we         = id_dispatch_i.we;
    end

endmodule

// File: logic/decoder.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module decoder (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         fetch_req_i,
    output logic                         fetch_ack_o,
    input  logic [`DATA_W-1:0]           pc_i,
    input  logic [`DATA_W-1:0]           inst_i,
    input  logic                         taken_i,
    output pipeline_types::id_dispatch_t id_o
);
    import isa_types::*;

    inst_field_t f;
    logic        ack_q;

    // ack rises once taken, falls after req drops
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else if (!ack_q && taken_i) begin
            ack_q <= 1'b1;
        end else if (ack_q && !fetch_req_i) begin
            ack_q <= 1'b0;
        end
    end

    assign fetch_ack_o = ack_q;
    assign f           = inst_i;

    always_comb begin
        id_o       = '0;
        id_o.valid = fetch_req_i && !ack_q;
        id_o.pc    = pc_i;
        id_o.inst  = inst_i;
        id_o.rd    = f.r3.rd;
        id_o.imm   = {{(`DATA_W-12){f.ri12.si12[11]}}, f.ri12.si12};
        case (f.r3.op)
            OP_ADD_W: id_o.aluop = ALU_ADD;
            OP_SUB_W: id_o.aluop = ALU_SUB;
            OP_SLT:   id_o.aluop = ALU_SLT;
            OP_AND:   id_o.aluop = ALU_AND;
            OP_OR:    id_o.aluop = ALU_OR;
            OP_XOR:   id_o.aluop = ALU_XOR;
            default:  id_o.aluop = ALU_NOP;
        endcase
        if (id_o.aluop != ALU_NOP) begin
            id_o.reg1_addr = f.r3.rj;
            id_o.reg2_addr = f.r3.rk;
            id_o.we        = 1'b1;
        end else if (f.ri12.op == OP_ADDI_W || f.ri12.op == OP_LD_W) begin
            id_o.aluop     = (f.ri12.op == OP_LD_W) ? ALU_LOAD : ALU_ADD;
            id_o.reg1_addr = f.ri12.rj;
            id_o.use_imm   = 1'b1;
            id_o.we        = 1'b1;
        end else if (f.ri12.op == OP_ST_W) begin
            // rd is the store source here
            id_o.aluop     = ALU_STORE;
            id_o.reg1_addr = f.ri12.rj;
            id_o.reg2_addr = f.ri12.rd;
            id_o.use_imm   = 1'b1;
        end else if (f.ri20.op == OP_LU12I_W) begin
            id_o.aluop   = ALU_LUI;
            id_o.imm     = {{(`DATA_W-20){f.ri20.si20[19]}}, f.ri20.si20};
            id_o.use_imm = 1'b1;
            id_o.we      = 1'b1;
        end
        if (id_o.rd == '0) begin
            id_o.we = 1'b0;
        end
    end

endmodule

// File: logic/stage_reg.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module stage_reg #(
    parameter type payload_t = pipeline_types::mem_wb_t,
    parameter int  STAGE     = `STAGE_ID
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  pipeline_types::pause_t pause_i,
    input  payload_t               d_i,
    output payload_t               q_o,
    output logic                   taken_o
);
    int   pause_stage;
    logic hold;
    logic bubble;

    if (STAGE >= `STAGE_WB) begin : g_bad_stage
        $error("stage_reg cannot feed from writeback");
    end

    // highest pausing stage or -1 when none
    always_comb begin
        if (pause_i.pause_mem) begin
            pause_stage = `STAGE_MEM;
        end else if (pause_i.pause_dispatch) begin
            pause_stage = `STAGE_DISPATCH;
        end else begin
            pause_stage = -1;
        end
    end

    assign hold    = pause_stage > STAGE;
    assign bubble  = pause_stage == STAGE;
    assign taken_o = !hold && !bubble && d_i.valid;

    always_ff @(posedge clk) begin
        if (!rst_n_i || bubble) begin
            q_o <= '0;
        end else if (!hold) begin
            q_o <= d_i;
        end
    end

    // any pause raised by a later stage freezes this register
    a_hold_on_later_pause: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((pause_i.pause_mem && STAGE < `STAGE_MEM) ||
         (pause_i.pause_dispatch && STAGE < `STAGE_DISPATCH)) |=> $stable(q_o));

endmodule

// File: regfile/regfile.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

module regfile (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  pipeline_types::mem_wb_t wb_i,
    dispatch_regfile.slave          rf
);
    logic [`DATA_W-1:0] regs [`REG_NUM];
    logic               wr_en;

    // r0 is never written
    assign wr_en = wb_i.valid && wb_i.we && (wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.wdata;
        end
    end

    // write-through of the value being committed
    assign rf.reg1_data = (rf.reg1_addr == '0) ? '0 :
                          (wr_en && wb_i.rd == rf.reg1_addr) ? wb_i.wdata :
                          regs[rf.reg1_addr];
    assign rf.reg2_data = (rf.reg2_addr == '0) ? '0 :
                          (wr_en && wb_i.rd == rf.reg2_addr) ? wb_i.wdata :
                          regs[rf.reg2_addr];

endmodule

// File: common/dispatch_regfile.sv
`timescale 1ns/10ps
`include "backend_consts.svh"

interface dispatch_regfile;
    logic [`REG_ADDR_W-1:0] reg1_addr;
    logic [`REG_ADDR_W-1:0] reg2_addr;
    logic [`DATA_W-1:0]     reg1_data;
    logic [`DATA_W-1:0]     reg2_data;

    modport master (
        output reg1_addr,
        output reg2_addr,
        input  reg1_data,
        input  reg2_data
    );

    modport slave (
        input  reg1_addr,
        input  reg2_addr,
        output reg1_data,
        output reg2_data
    );
endinterface

// File: common/pipeline_types.sv
`include "backend_consts.svh"

package pipeline_types;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     inst;
        isa_types::aluop_t      aluop;
        logic [`REG_ADDR_W-1:0] reg1_addr;
        // rk for 3R forms, rd for st.w
        logic [`REG_ADDR_W-1:0] reg2_addr;
        logic                   use_imm;
        logic [`DATA_W-1:0]     imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
    } id_dispatch_t;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     inst;
        isa_types::aluop_t      aluop;
        logic [`DATA_W-1:0]     opa;
        logic [`DATA_W-1:0]     opb;
        logic [`DATA_W-1:0]     store_data;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
    } dispatch_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     inst;
        isa_types::aluop_t      aluop;
        // ALU result or effective address
        logic [`DATA_W-1:0]     result;
        logic [`DATA_W-1:0]     store_data;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   we;
    } ex_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     inst;
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`DATA_W-1:0]     wdata;
    } mem_wb_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     data;
    } push_forward_t;

    typedef struct packed {
        logic pause_dispatch;
        logic pause_mem;
    } pause_t;

endpackage

// File: common/isa_types.sv
package isa_types;

    typedef enum logic [3:0] {
        ALU_NOP   = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_AND   = 4'd3,
        ALU_OR    = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SLT   = 4'd6,
        ALU_LUI   = 4'd7,
        ALU_LOAD  = 4'd8,
        ALU_STORE = 4'd9
    } aluop_t;

    // 3R opcodes in inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;
    // 2RI12 opcodes in inst[31:22]
    localparam logic [9:0]  OP_ADDI_W = 10'h00a;
    localparam logic [9:0]  OP_LD_W   = 10'h0a2;
    localparam logic [9:0]  OP_ST_W   = 10'h0a6;
    // 1RI20 opcodes in inst[31:25]
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;

    typedef struct packed {
        logic [16:0] op;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]  op;
        logic [11:0] si12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]  op;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_1ri20_t;

    typedef union packed {
        fmt_3r_t    r3;
        fmt_2ri12_t ri12;
        fmt_1ri20_t ri20;
    } inst_field_t;

endpackage

// File: common/backend_consts.svh
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// datapath sizes
`define DATA_W     32
`define REG_NUM    32
`define REG_ADDR_W 5

// stage indices for the pause rule
`define STAGE_ID       0
`define STAGE_DISPATCH 1
`define STAGE_EX       2
`define STAGE_MEM      3
`define STAGE_WB       4

`endif
